// File: BranchPredictor.sv
`default_nettype none
`timescale 1ns/1ns

`include "riscv_config.svh"

module BranchPredictor
	import FrontEndPkg::*;
(
	input wire clk,
	input wire rst,
	input wire pcT lookupPc, // address of the word being fetched
	output logic predictTaken,
	output pcT predictTarget,
	input wire update,       // a branch or jump resolved in decode this cycle
	input wire pcT updatePc,
	input wire updateTaken,
	input wire pcT updateTarget
);

	localparam counterT WeakTaken = 2'd2;    // first state on a taken miss
	localparam counterT WeakNotTaken = 2'd1; // first state on a not taken miss

	btbTagT tagMem [`BTB_ENTRIES];
	pcT targetMem [`BTB_ENTRIES];
	counterT counterMem [`BTB_ENTRIES];
	logic [`BTB_ENTRIES-1:0] entryValid; // only these bits see reset

	btbIdxT lookupIdx;
	btbIdxT updateIdx;
	btbTagT lookupTag;
	btbTagT updateTag;
	logic lookupHit;
	logic updateHit;
	counterT oldCounter;
	counterT newCounter;

	assign lookupIdx = lookupPc[BtbIdxBits+1:2];
	assign lookupTag = lookupPc[`XLEN-1:BtbIdxBits+2];
	assign updateIdx = updatePc[BtbIdxBits+1:2];
	assign updateTag = updatePc[`XLEN-1:BtbIdxBits+2];

	// read is combinational so a write shows up on the following cycle
	assign lookupHit = entryValid[lookupIdx] && (tagMem[lookupIdx] == lookupTag);
	assign predictTaken = lookupHit && counterMem[lookupIdx][1]; // msb set means 2 or 3
	assign predictTarget = targetMem[lookupIdx];

	assign updateHit = entryValid[updateIdx] && (tagMem[updateIdx] == updateTag);
	assign oldCounter = counterMem[updateIdx];

	always_comb begin
		if (!updateHit) begin
			newCounter = updateTaken ? WeakTaken : WeakNotTaken; // fresh entry starts weak
		end else if (updateTaken) begin
			newCounter = (oldCounter == 2'd3) ? oldCounter : oldCounter + 2'd1;
		end else begin
			newCounter = (oldCounter == 2'd0) ? oldCounter : oldCounter - 2'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			entryValid <= '0;
		end else if (update) begin
			entryValid[updateIdx] <= 1'b1;
		end
	end

	// an entry is replaced as a whole, a conflicting PC simply evicts the old one
	always_ff @(posedge clk) begin
		if (update) begin
			tagMem[updateIdx] <= updateTag;
			targetMem[updateIdx] <= updateTarget;
			counterMem[updateIdx] <= newCounter;
		end
	end

endmodule

`default_nettype wire

// File: CheckForControlToUse.sv
`default_nettype none
`timescale 1ns/1ns

module CheckForControlToUse
	import RiscvPkg::*;
#(
	parameter bit LoadOnly = 1'b0 // set for the EX copy, where only a load is still unresolved
) (
	input wire instrT fetchInstr, // word coming back from the bus
	input wire instrT downInstr,  // instruction further down the pipeline
	input wire downRegWrite,
	output logic stall
);

	regIdxT downRd;
	logic isControl; // branches compare in decode, so their sources must be ready
	logic writerCounts;
	logic rs1Hit;
	logic rs2Hit;

	assign downRd = rdOf(downInstr);

	// JAL has no source register and is left out
	assign isControl = (opcodeOf(fetchInstr) == BRANCH) || (opcodeOf(fetchInstr) == JALR);

	// an ALU result in EX is forwarded in time, a load result is not
	assign writerCounts = downRegWrite && (!LoadOnly || (opcodeOf(downInstr) == LOAD));

	assign rs1Hit = readsRs1(fetchInstr) && (rs1Of(fetchInstr) == downRd);
	assign rs2Hit = readsRs2(fetchInstr) && (rs2Of(fetchInstr) == downRd);

	assign stall = isControl && writerCounts && (downRd != 5'd0) && (rs1Hit || rs2Hit);

endmodule

`default_nettype wire

// File: CheckForLoadToUse.sv
`default_nettype none
`timescale 1ns/1ns

module CheckForLoadToUse
	import RiscvPkg::*;
(
	input wire instrT fetchInstr,  // word coming back from the bus
	input wire instrT decodeInstr, // word sitting in IF/ID
	input wire regWriteId,
	input wire memReadId,
	output logic stall
);

	regIdxT loadRd; // destination of the load in decode
	logic rs1Hit;
	logic rs2Hit;

	assign loadRd = rdOf(decodeInstr);

	// a field only counts when the fetched format really reads it
	assign rs1Hit = readsRs1(fetchInstr) && (rs1Of(fetchInstr) == loadRd);
	assign rs2Hit = readsRs2(fetchInstr) && (rs2Of(fetchInstr) == loadRd);

	// x0 never carries a dependency
	assign stall = memReadId && regWriteId && (loadRd != 5'd0) && (rs1Hit || rs2Hit);

endmodule

`default_nettype wire

// File: FetchUnit.sv
`default_nettype none
`timescale 1ns/1ns

`include "riscv_config.svh"

module FetchUnit
	import RiscvPkg::*;
	import FrontEndPkg::*;
(
	input wire clk,
	input wire rst,
	output pcT wbAdr,
	output logic wbCyc,
	output logic wbStb,
	input wire instrT wbDatIn,
	input wire wbAck,
	input wire pcEnable,
	input wire flushIfId,
	input wire mispredict,
	input wire pcT redirectPc,
	input wire predictTaken,  // BTB lookup on fetchPc
	input wire pcT predictTarget,
	output pcT fetchPc,
	output logic fetchValid,  // wbDatIn holds a word that counts this cycle
	output instrT instrIfId,
	output pcT pcIfId,
	output logic validIfId,
	output logic predictTakenIfId,
	output logic halted
);

	fetchStateT state;
	pcT pc;
	pcT pcNext;
	pcT seqPc;     // where fetch goes when the word is accepted
	pcT adrReg;    // address of the outstanding bus cycle
	logic discard; // a redirect arrived while a bus cycle was open
	logic accept;
	logic haltNow;

	assign wbCyc = (state == BUS);
	assign wbStb = (state == BUS); // classic cycles, strobe follows cycle
	assign wbAdr = adrReg;
	assign fetchPc = pc;
	assign halted = (state == HALT);

	// the ack of a cycle opened before a redirect returns a stale word
	assign fetchValid = (state == BUS) && wbAck && !discard;
	assign accept = fetchValid && pcEnable && !flushIfId;
	assign haltNow = fetchValid && !pcEnable && !flushIfId; // only an ECALL gets here

	assign seqPc = predictTaken ? predictTarget : pc + pcT'(4);

	always_comb begin
		pcNext = pc; // a stall keeps the PC so the same word is fetched again
		if (mispredict) begin
			pcNext = redirectPc;
		end else if (accept) begin
			pcNext = seqPc;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			pc <= `RESET_PC;
			discard <= 1'b0;
		end else begin
			pc <= pcNext;
			case (state)
				IDLE: state <= BUS; // one idle cycle between bus cycles
				BUS: begin
					if (wbAck) begin
						discard <= 1'b0;
						state <= haltNow ? HALT : IDLE;
					end else if (mispredict) begin
						discard <= 1'b1; // finish the cycle but drop its data
					end
				end
				HALT: state <= HALT;
				default: state <= IDLE;
			endcase
		end
	end

	// address is captured at the start of the cycle and held until the ack
	always_ff @(posedge clk) begin
		if (state == IDLE) begin
			adrReg <= pcNext;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			instrIfId <= NOP;
			validIfId <= 1'b0;
			predictTakenIfId <= 1'b0;
		end else if (flushIfId) begin
			instrIfId <= NOP; // bubble for a stall or a wrong path
			validIfId <= 1'b0;
			predictTakenIfId <= 1'b0;
		end else if (fetchValid) begin
			instrIfId <= wbDatIn;
			validIfId <= 1'b1;
			predictTakenIfId <= predictTaken;
		end
	end

	always_ff @(posedge clk) begin
		if (fetchValid && !flushIfId) begin
			pcIfId <= pc;
		end
	end

endmodule

`default_nettype wire

// File: FrontEndPkg.sv
`default_nettype none

`include "riscv_config.svh"

package FrontEndPkg;

	typedef logic [`XLEN-1:0] pcT; // instruction address
	typedef logic [1:0] counterT;  // two bit saturating branch counter

	localparam int BtbIdxBits = $clog2(`BTB_ENTRIES);
	// word aligned PCs drop bits [1:0], the index sits right above them
	localparam int BtbTagBits = `XLEN - BtbIdxBits - 2;

	typedef logic [BtbIdxBits-1:0] btbIdxT;
	typedef logic [BtbTagBits-1:0] btbTagT; // upper PC bits kept per entry

	// fetch sequencer, HALT is only left through reset
	typedef enum logic [1:0] {
		IDLE,
		BUS,
		HALT
	} fetchStateT;

endpackage

`default_nettype wire

// File: HazardDetection.sv
`default_nettype none
`timescale 1ns/1ns

module HazardDetection
	import RiscvPkg::*;
	import FrontEndPkg::*;
(
	input wire instrT fetchInstr,   // word on the bus this cycle
	input wire fetchValid,
	input wire instrT decodeInstr,  // IF/ID contents
	input wire regWriteId,
	input wire memReadId,
	input wire instrT instrEx,      // instruction one stage further on
	input wire regWriteEx,
	input wire branch,
	input wire jump,
	input wire takeBranch,          // direction resolved in decode
	input wire predictTakenIfId,
	input wire decodeValid,
	input wire pcT pcIfId,
	input wire pcT branchTarget,
	output logic pcEnable,
	output logic flushIfId,
	output logic mispredict,
	output pcT redirectPc
);

	logic stallLoadToUse;
	logic stallAluToBranch;
	logic stallLoadToBranch;
	logic stall;
	logic fetchEcall;

	CheckForLoadToUse checkLoadToUse (
		.fetchInstr(fetchInstr),
		.decodeInstr(decodeInstr),
		.regWriteId(regWriteId),
		.memReadId(memReadId),
		.stall(stallLoadToUse)
	);

	// any writer in decode is too late for a branch compare in the next cycle
	CheckForControlToUse #(.LoadOnly(1'b0)) checkAluToBranch (
		.fetchInstr(fetchInstr),
		.downInstr(decodeInstr),
		.downRegWrite(regWriteId),
		.stall(stallAluToBranch)
	);

	// in EX only a load still lacks its result
	CheckForControlToUse #(.LoadOnly(1'b1)) checkLoadToBranch (
		.fetchInstr(fetchInstr),
		.downInstr(instrEx),
		.downRegWrite(regWriteEx),
		.stall(stallLoadToBranch)
	);

	assign mispredict = decodeValid && (branch || jump) && (takeBranch != predictTakenIfId);
	assign redirectPc = takeBranch ? branchTarget : pcIfId + pcT'(4); // fall through on not taken

	// checks only mean something while a fetched word is on the bus
	assign stall = fetchValid && (stallLoadToUse || stallAluToBranch || stallLoadToBranch);
	assign fetchEcall = fetchValid && (fetchInstr == ECALL);

	assign pcEnable = !(stall || fetchEcall);
	assign flushIfId = mispredict || stall; // a stalled word becomes a bubble and is refetched

endmodule

`default_nettype wire

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_PipelineFrontEnd
DUT_TOP ?= PipelineFrontEnd
FILELIST ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := riscv_config.svh

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: PipelineFrontEnd.sv
`default_nettype none
`timescale 1ns/1ns

module PipelineFrontEnd
	import RiscvPkg::*;
	import FrontEndPkg::*;
(
	input wire clk,
	input wire rst,
	output pcT wbAdr,
	output logic wbCyc,
	output logic wbStb,
	input wire instrT wbDatIn,
	input wire wbAck,
	input wire regWriteId,
	input wire memReadId,
	input wire instrT instrEx,
	input wire regWriteEx,
	input wire branch,
	input wire jump,
	input wire takeBranch,
	input wire pcT branchTarget,
	output instrT instrIfId,
	output pcT pcIfId,
	output logic validIfId,
	output logic predictTakenIfId,
	output logic halted
);

	logic pcEnable;
	logic flushIfId;
	logic mispredict;
	pcT redirectPc;
	pcT fetchPc;
	logic fetchValid;
	logic predictTaken;
	pcT predictTarget;
	wire decodeResolved = validIfId && (branch || jump); // BTB learns from every resolved word

	FetchUnit fetchUnit (
		.clk(clk),
		.rst(rst),
		.wbAdr(wbAdr),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbDatIn(wbDatIn),
		.wbAck(wbAck),
		.pcEnable(pcEnable),
		.flushIfId(flushIfId),
		.mispredict(mispredict),
		.redirectPc(redirectPc),
		.predictTaken(predictTaken),
		.predictTarget(predictTarget),
		.fetchPc(fetchPc),
		.fetchValid(fetchValid),
		.instrIfId(instrIfId),
		.pcIfId(pcIfId),
		.validIfId(validIfId),
		.predictTakenIfId(predictTakenIfId),
		.halted(halted)
	);

	HazardDetection hazardDetection (
		.fetchInstr(wbDatIn),
		.fetchValid(fetchValid),
		.decodeInstr(instrIfId),
		.regWriteId(regWriteId),
		.memReadId(memReadId),
		.instrEx(instrEx),
		.regWriteEx(regWriteEx),
		.branch(branch),
		.jump(jump),
		.takeBranch(takeBranch),
		.predictTakenIfId(predictTakenIfId),
		.decodeValid(validIfId),
		.pcIfId(pcIfId),
		.branchTarget(branchTarget),
		.pcEnable(pcEnable),
		.flushIfId(flushIfId),
		.mispredict(mispredict),
		.redirectPc(redirectPc)
	);

	BranchPredictor branchPredictor (
		.clk(clk),
		.rst(rst),
		.lookupPc(fetchPc),
		.predictTaken(predictTaken),
		.predictTarget(predictTarget),
		.update(decodeResolved),
		.updatePc(pcIfId),
		.updateTaken(takeBranch),
		.updateTarget(branchTarget)
	);

endmodule

`default_nettype wire

// File: PipelineFrontEnd_assertions.sv
`default_nettype none
`timescale 1ns/1ns

module PipelineFrontEndAssertions
	import FrontEndPkg::*;
(
	input wire clk,
	input wire rst,
	input wire pcT wbAdr,
	input wire wbCyc,
	input wire wbStb,
	input wire wbAck,
	input wire halted,
	input wire flushIfId, // internal control output of the hazard unit
	input wire validIfId
);

	// classic cycles without wait states on the master side, strobe follows cycle
	strobeFollowsCycle: assert property (@(posedge clk) disable iff (rst)
		wbStb == wbCyc)
		else $error("wbStb and wbCyc differ");

	// the master holds the request until the slave acks it
	addressHeld: assert property (@(posedge clk) disable iff (rst)
		wbCyc && !wbAck |=> wbCyc && $stable(wbAdr))
		else $error("wbAdr or wbCyc changed while waiting for wbAck");

	// at least one idle cycle follows every transfer
	idleAfterAck: assert property (@(posedge clk) disable iff (rst)
		wbCyc && wbAck |=> !wbCyc)
		else $error("wbCyc stayed high after wbAck");

	noBusWhileHalted: assert property (@(posedge clk) disable iff (rst)
		halted |-> !wbCyc)
		else $error("bus cycle started while fetch is halted");

	// a flushed IF/ID always carries a bubble
	bubbleAfterFlush: assert property (@(posedge clk) disable iff (rst)
		flushIfId |=> !validIfId)
		else $error("validIfId high after a flush");

endmodule

`default_nettype wire

// File: RiscvPkg.sv
`default_nettype none

package RiscvPkg;

	typedef logic [31:0] instrT; // one RV32I instruction word
	typedef logic [4:0] regIdxT; // index into the 32 entry register file

	// major opcodes of the base integer set, bits [6:0] of the word
	typedef enum logic [6:0] {
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		OPIMM  = 7'b0010011,
		OP     = 7'b0110011,
		LUI    = 7'b0110111,
		AUIPC  = 7'b0010111,
		BRANCH = 7'b1100011,
		JAL    = 7'b1101111,
		JALR   = 7'b1100111,
		SYSTEM = 7'b1110011
	} opcodeT;

	localparam instrT NOP = 32'h00000013;   // addi x0, x0, 0 used as the pipeline bubble
	localparam instrT ECALL = 32'h00000073; // environment call, stops the fetch

	function automatic opcodeT opcodeOf(input instrT instr);
		return opcodeT'(instr[6:0]);
	endfunction

	function automatic regIdxT rdOf(input instrT instr);
		return instr[11:7];
	endfunction

	function automatic regIdxT rs1Of(input instrT instr);
		return instr[19:15];
	endfunction

	function automatic regIdxT rs2Of(input instrT instr);
		return instr[24:20];
	endfunction

	// U and J formats carry immediate bits where rs1 would sit, so they never read it
	function automatic logic readsRs1(input instrT instr);
		case (opcodeOf(instr))
			LOAD, STORE, OPIMM, OP, BRANCH, JALR: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	// only the S, B and R formats have a real rs2 field
	function automatic logic readsRs2(input instrT instr);
		case (opcodeOf(instr))
			STORE, OP, BRANCH: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

endpackage

`default_nettype wire

// File: riscv_config.svh
`ifndef RISCV_CONFIG_SVH
`define RISCV_CONFIG_SVH

// data and address width of the core
`define XLEN 32

// number of branch target buffer entries, must be a power of two
`define BTB_ENTRIES 64

// address of the first instruction fetched after reset
`define RESET_PC 32'h00000000

`endif

// File: tb_PipelineFrontEnd.sv
`default_nettype none
`timescale 1ns/1ns

`include "riscv_config.svh"

module tb_PipelineFrontEnd
	import RiscvPkg::*;
	import FrontEndPkg::*;
();

	localparam int ClkPeriod = 8;
	localparam int ResetCycles = 5;
	localparam int WordsToRun = 2000;
	localparam int CyclesPerWord = 12;  // worst case bus wait plus refetch and flush cycles
	localparam int WatchdogCycles = WordsToRun * CyclesPerWord;
	localparam int HaltHoldCycles = 6;  // cycles the halted front end is watched before reset
	localparam int MemWords = 256;      // the program window, addressed by wbAdr[9:2]
	localparam logic [31:0] Seed = 32'h5d54630f;
	localparam instrT EcallWord = 32'h00000073;

	logic clk;
	logic rst;
	pcT wbAdr;
	logic wbCyc;
	logic wbStb;
	instrT wbDatIn;
	logic wbAck;
	logic regWriteId;
	logic memReadId;
	instrT instrEx;
	logic regWriteEx;
	logic branch;
	logic jump;
	logic takeBranch;
	pcT branchTarget;
	instrT instrIfId;
	pcT pcIfId;
	logic validIfId;
	logic predictTakenIfId;
	logic halted;

	instrT imem [MemWords];
	logic [31:0] lfsrState;
	logic slaveBusy;  // the slave has drawn a wait for the open cycle
	int slaveDelay;

	// reference model of the front end, updated once per clock
	fetchStateT mState;
	pcT mPc;
	pcT mAdr;
	logic mDiscard;
	instrT mIfInstr;
	pcT mIfPc;
	logic mIfValid;
	logic mIfPred;
	logic mIfFresh;   // decode has not resolved this word yet
	instrT mExInstr;  // one entry EX stage, advances whenever IF/ID is written
	pcT btbPc [`BTB_ENTRIES];
	pcT btbTarget [`BTB_ENTRIES];
	counterT btbCount [`BTB_ENTRIES];
	logic [`BTB_ENTRIES-1:0] btbValid;

	int retired;
	int stalls;
	int mispredicts;
	int discards;
	int predictedTaken;
	int halts;
	int haltCycles;

	initial clk = 1'b0;
	always #(ClkPeriod / 2) clk = ~clk;

	PipelineFrontEnd uut (
		.clk(clk),
		.rst(rst),
		.wbAdr(wbAdr),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbDatIn(wbDatIn),
		.wbAck(wbAck),
		.regWriteId(regWriteId),
		.memReadId(memReadId),
		.instrEx(instrEx),
		.regWriteEx(regWriteEx),
		.branch(branch),
		.jump(jump),
		.takeBranch(takeBranch),
		.branchTarget(branchTarget),
		.instrIfId(instrIfId),
		.pcIfId(pcIfId),
		.validIfId(validIfId),
		.predictTakenIfId(predictTakenIfId),
		.halted(halted)
	);

	bind PipelineFrontEnd PipelineFrontEndAssertions busChecks (
		.clk(clk),
		.rst(rst),
		.wbAdr(wbAdr),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbAck(wbAck),
		.halted(halted),
		.flushIfId(flushIfId),
		.validIfId(validIfId)
	);

	// 32 bit Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit returned
	function automatic logic [31:0] randomBits(input int count);
		logic [31:0] value;
		logic feedback;
		int i;
		value = '0;
		for (i = 0; i < count; i++) begin
			feedback = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
			lfsrState = {lfsrState[30:0], feedback};
			value = {value[30:0], feedback};
		end
		return value;
	endfunction

	function automatic opcodeT wordOpcode(input instrT w);
		return opcodeT'(w[6:0]);
	endfunction

	// true when a source field that the format really uses names r
	function automatic logic readsReg(input instrT w, input regIdxT r);
		logic rs1Match;
		logic rs2Match;
		rs1Match = (w[19:15] == r);
		rs2Match = (w[24:20] == r);
		case (wordOpcode(w))
			BRANCH, STORE, OP: return rs1Match || rs2Match;
			LOAD, OPIMM, JALR: return rs1Match;
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic writesReg(input instrT w);
		case (wordOpcode(w))
			LOAD, OPIMM, OP, LUI, AUIPC, JAL, JALR: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic loadUseHazard(input instrT fetched, input instrT dec,
			input logic regWrite, input logic memRead);
		regIdxT rd;
		rd = dec[11:7];
		return memRead && regWrite && (rd != 5'd0) && readsReg(fetched, rd);
	endfunction

	// a branch or JALR compares its sources in decode, so its producer must be done
	function automatic logic controlHazard(input instrT fetched, input instrT down,
			input logic downWrite, input logic loadOnly);
		regIdxT rd;
		logic isControl;
		rd = down[11:7];
		isControl = (wordOpcode(fetched) == BRANCH) || (wordOpcode(fetched) == JALR);
		if (loadOnly && (wordOpcode(down) != LOAD)) begin
			return 1'b0;
		end
		return isControl && downWrite && (rd != 5'd0) && readsReg(fetched, rd);
	endfunction

	function automatic btbIdxT btbSlot(input pcT pc);
		return pc[$clog2(`BTB_ENTRIES)+1:2];
	endfunction

	// opcodes biased toward hazards, registers kept to x0..x3 so they collide often
	function automatic instrT makeWord();
		logic [5:0] kind;
		regIdxT rd;
		regIdxT rs1;
		regIdxT rs2;
		logic [2:0] funct3;
		logic [6:0] upper;
		opcodeT op;
		kind = 6'(randomBits(6));
		rd = regIdxT'(randomBits(2));
		rs1 = regIdxT'(randomBits(2));
		rs2 = regIdxT'(randomBits(2));
		funct3 = 3'(randomBits(3));
		upper = 7'(randomBits(7));
		if (kind == 6'd0) begin
			return EcallWord; // about one word in 64
		end else if (kind < 6'd15) begin
			op = LOAD;
		end else if (kind < 6'd27) begin
			op = BRANCH;
		end else if (kind < 6'd31) begin
			op = JAL;
		end else begin
			op = (randomBits(1) != 32'd0) ? OP : OPIMM;
		end
		return {upper, rs2, rs1, funct3, rd, op};
	endfunction

	task automatic fillMemory();
		int i;
		for (i = 0; i < MemWords; i++) begin
			imem[i[7:0]] = makeWord();
		end
	endtask

	task automatic checkValue(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
			$display("Test FAILED");
			$fatal(1, "front end output differs from the reference model");
		end
	endtask

	task automatic updateBtbModel(input pcT pc, input logic taken, input pcT target);
		btbIdxT s;
		logic hit;
		s = btbSlot(pc);
		hit = btbValid[s] && (btbPc[s] == pc);
		if (!hit) begin
			btbCount[s] = taken ? 2'd2 : 2'd1; // a new entry starts weak
		end else if (taken && (btbCount[s] != 2'd3)) begin
			btbCount[s] = btbCount[s] + 2'd1;
		end else if (!taken && (btbCount[s] != 2'd0)) begin
			btbCount[s] = btbCount[s] - 2'd1;
		end
		btbPc[s] = pc;
		btbTarget[s] = target;
		btbValid[s] = 1'b1;
	endtask

	task automatic resetModel();
		mState = IDLE;
		mPc = `RESET_PC;
		mAdr = `RESET_PC;
		mDiscard = 1'b0;
		mIfInstr = NOP;
		mIfPc = '0;
		mIfValid = 1'b0;
		mIfPred = 1'b0;
		mIfFresh = 1'b0;
		mExInstr = NOP;
		btbValid = '0;
		slaveBusy = 1'b0;
		slaveDelay = 0;
	endtask

	task automatic applyReset();
		rst = 1'b1;
		wbAck = 1'b0;
		wbDatIn = '0;
		regWriteId = 1'b0;
		memReadId = 1'b0;
		instrEx = NOP;
		regWriteEx = 1'b0;
		branch = 1'b0;
		jump = 1'b0;
		takeBranch = 1'b0;
		branchTarget = '0;
		repeat (ResetCycles) @(negedge clk);
		rst = 1'b0;
		resetModel();
	endtask

	task automatic compareOutputs();
		checkValue("wbCyc", 32'(mState == BUS), 32'(wbCyc));
		checkValue("wbStb", 32'(mState == BUS), 32'(wbStb));
		checkValue("halted", 32'(mState == HALT), 32'(halted));
		if (mState == BUS) begin
			checkValue("wbAdr", mAdr, wbAdr);
		end
		checkValue("validIfId", 32'(mIfValid), 32'(validIfId));
		checkValue("instrIfId", mIfInstr, instrIfId);
		checkValue("predictTakenIfId", 32'(mIfPred), 32'(predictTakenIfId));
		if (mIfValid) begin
			checkValue("pcIfId", mIfPc, pcIfId); // pcIfId is left as it was on a flush
		end
	endtask

	// bus slave with a random wait of 0 to 3 cycles per transfer
	task automatic driveBus();
		wbAck = 1'b0;
		wbDatIn = '0;
		if (wbCyc) begin
			if (!slaveBusy) begin
				slaveBusy = 1'b1;
				slaveDelay = int'(randomBits(2));
			end
			if (slaveDelay == 0) begin
				wbAck = 1'b1;
				wbDatIn = imem[wbAdr[9:2]];
			end else begin
				slaveDelay--;
			end
		end else begin
			slaveBusy = 1'b0;
		end
	endtask

	// decode and EX stages as seen by the front end
	task automatic driveDecode();
		opcodeT op;
		logic resolveNow;
		op = wordOpcode(mIfInstr);
		regWriteId = mIfValid && writesReg(mIfInstr);
		memReadId = mIfValid && (op == LOAD);
		// decode may take a few cycles, but resolves at the latest when the next word acks
		resolveNow = mIfFresh && ((randomBits(1) != 32'd0) || wbAck);
		branch = resolveNow && (op == BRANCH);
		jump = resolveNow && (op == JAL);
		takeBranch = jump;
		if (branch) begin
			takeBranch = (randomBits(1) != 32'd0);
		end
		// the upper immediate bits pick the target word inside the program window
		branchTarget = pcT'({mIfInstr[31:24], 2'b00});
		instrEx = mExInstr;
		regWriteEx = writesReg(mExInstr);
	endtask

	task automatic stepModel();
		btbIdxT s;
		logic fetchOk;
		logic predTaken;
		logic mispred;
		logic stall;
		logic ecall;
		logic flush;
		pcT redirect;
		pcT pcNext;
		fetchOk = (mState == BUS) && wbAck && !mDiscard;
		s = btbSlot(mPc);
		predTaken = btbValid[s] && (btbPc[s] == mPc) && (btbCount[s] >= 2'd2);
		mispred = mIfValid && (branch || jump) && (takeBranch != mIfPred);
		redirect = takeBranch ? branchTarget : mIfPc + 32'd4;
		stall = fetchOk && (loadUseHazard(wbDatIn, mIfInstr, regWriteId, memReadId)
			|| controlHazard(wbDatIn, mIfInstr, regWriteId, 1'b0)
			|| controlHazard(wbDatIn, mExInstr, regWriteEx, 1'b1));
		ecall = fetchOk && (wbDatIn == EcallWord);
		flush = mispred || stall;

		pcNext = mPc; // a stalled word is fetched again from the same PC
		if (mispred) begin
			pcNext = redirect;
		end else if (fetchOk && !stall && !ecall) begin
			pcNext = predTaken ? btbTarget[s] : mPc + 32'd4;
		end

		if (mIfValid && (branch || jump)) begin
			updateBtbModel(mIfPc, takeBranch, branchTarget);
		end
		if (flush || fetchOk) begin
			mExInstr = mIfInstr;
		end

		if (branch || jump) begin
			mIfFresh = 1'b0; // a word is resolved only once
		end
		if (flush) begin
			mIfInstr = NOP;
			mIfValid = 1'b0;
			mIfPred = 1'b0;
			mIfFresh = 1'b0;
		end else if (fetchOk) begin
			mIfInstr = wbDatIn;
			mIfPc = mPc;
			mIfValid = 1'b1;
			mIfPred = predTaken;
			mIfFresh = 1'b1;
			retired++;
			predictedTaken += int'(predTaken);
		end

		case (mState)
			IDLE: begin
				mAdr = pcNext;
				mState = BUS;
			end
			BUS: begin
				if (wbAck) begin
					mDiscard = 1'b0;
					mState = (ecall && !flush) ? HALT : IDLE;
				end else if (mispred) begin
					mDiscard = 1'b1;
					discards++;
				end
			end
			default: mState = HALT;
		endcase
		mPc = pcNext;

		stalls += int'(stall);
		mispredicts += int'(mispred);
		halts += int'(mState == HALT && ecall);
	endtask

	initial begin
		#(WatchdogCycles * ClkPeriod);
		$display("timeout after %0d cycles with %0d words retired", WatchdogCycles, retired);
		$display("Test FAILED");
		$fatal(1, "the run did not finish in time");
	end

	initial begin
		lfsrState = Seed;
		retired = 0;
		stalls = 0;
		mispredicts = 0;
		discards = 0;
		predictedTaken = 0;
		halts = 0;
		haltCycles = 0;
		fillMemory();
		applyReset();
		while (retired < WordsToRun) begin
			compareOutputs();
			if (mState == HALT) begin
				haltCycles++;
				if (haltCycles > HaltHoldCycles) begin
					haltCycles = 0;
					applyReset(); // only a reset restarts fetch after an ECALL
					continue;
				end
			end
			driveBus();
			driveDecode();
			stepModel();
			@(negedge clk);
		end
		compareOutputs();
		$display("%0d words, %0d stalls, %0d mispredictions, %0d discards", retired, stalls,
			mispredicts, discards);
		$display("%0d predicted taken, %0d halts", predictedTaken, halts);
		if ((stalls == 0) || (mispredicts == 0) || (discards == 0) || (predictedTaken == 0)
				|| (halts == 0)) begin
			$display("the stimulus never reached a stall, misprediction, discard, prediction or halt");
			$display("Test FAILED");
			$fatal(1, "a front end behavior was not exercised");
		end else begin
			$display("Test OK");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+.
RiscvPkg.sv
FrontEndPkg.sv
CheckForLoadToUse.sv
CheckForControlToUse.sv
BranchPredictor.sv
FetchUnit.sv
HazardDetection.sv
PipelineFrontEnd.sv
PipelineFrontEnd_assertions.sv
tb_PipelineFrontEnd.sv
